/* design/sqPkg.sv */
package sqPkg;

    // Default queue depth
    localparam int SQ_ENTRIES = 8;

    // One extra bit keeps age compares correct across wrap-around
    localparam int SQN_W = $clog2(SQ_ENTRIES) + 1;

    typedef logic [SQN_W-1:0] sqN_t;
    typedef logic [29:0] wordAddr_t;
    typedef logic [3:0] byteMask_t;

    typedef struct packed {
        logic valid;
        logic addrAvail;
        logic loaded;
        logic ready;
        sqN_t sqN;
        wordAddr_t addr;
        byteMask_t wmask;
        logic [31:0] data;
    } sqEntry_t;

    // True when a was allocated before b
    function automatic logic isOlder(sqN_t a, sqN_t b);
        sqN_t diff;
        diff = a - b;
        return diff[SQN_W-1];
    endfunction

    // Move right-justified store data into the lanes selected by mask
    function automatic logic [31:0] alignData(logic [31:0] raw, byteMask_t mask);
        case (mask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return {4{raw[7:0]}};
            4'b0011, 4'b1100: return {2{raw[15:0]}};
            default: return raw;
        endcase
    endfunction

    // Bytes touched by a load of the given size at a byte offset
    function automatic byteMask_t readMaskOf(logic [1:0] size, logic [1:0] offset);
        case (size)
            2'd0: return byteMask_t'(4'b0001 << offset);
            2'd1: return (offset == 2'd2) ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

endpackage

/* design/sqStateIf.sv */
`timescale 1ns/1ps

interface sqStateIf import sqPkg::*; #(
    parameter int numEntries = SQ_ENTRIES
) ();

    // Entry state as seen by the drain and lookup stages
    sqEntry_t entries [numEntries];

    // Full sequence pointers whose low bits index the array
    sqN_t head;
    sqN_t tail;

    // Retire strobe for the head entry
    logic deq;

    modport array (
        output entries,
        output head,
        output tail,
        input deq
    );

    modport drain (
        input entries,
        input head,
        output deq
    );

    modport lookup (
        input entries,
        input head,
        input tail
    );

endinterface

/* design/sqEntryArray.sv */
`timescale 1ns/1ps

module sqEntryArray import sqPkg::*; #(
    parameter int numEntries = SQ_ENTRIES
) (
    input logic clk,
    input logic rst,

    // Allocation
    input logic alloc,
    output sqN_t allocSqN,
    output logic full,
    output logic empty,

    // Address write from the AGU
    input logic agValid,
    input sqN_t agSqN,
    input logic [31:0] agAddr,
    input byteMask_t agMask,

    // Store data write
    input logic dataValid,
    input sqN_t dataSqN,
    input logic [31:0] dataIn,

    // Everything older than this is committed
    input sqN_t commitSqN,

    sqStateIf.array st
);

    localparam int idxW = $clog2(numEntries);

    logic [idxW-1:0] headIdx;
    logic [idxW-1:0] tailIdx;
    logic [idxW-1:0] agIdx;
    logic [idxW-1:0] dataIdx;

    logic doAlloc;
    sqN_t nextHead;
    sqN_t nextTail;
    sqN_t nextCount;

    assign headIdx = st.head[idxW-1:0];
    assign tailIdx = st.tail[idxW-1:0];
    assign agIdx = agSqN[idxW-1:0];
    assign dataIdx = dataSqN[idxW-1:0];

    // New stores take the tail sequence number
    assign allocSqN = st.tail;

    // Allocation is dropped while the queue is full
    assign doAlloc = alloc && !full;

    assign nextHead = st.head + sqN_t'(st.deq);
    assign nextTail = st.tail + sqN_t'(doAlloc);

    // Pointers carry one spare bit, so the difference is the exact occupancy
    assign nextCount = nextTail - nextHead;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numEntries; i++) begin
                st.entries[i].valid <= 1'b0;
                st.entries[i].addrAvail <= 1'b0;
                st.entries[i].loaded <= 1'b0;
                st.entries[i].ready <= 1'b0;
            end
            st.head <= '0;
            st.tail <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end else begin
            // Commit tracking
            for (int i = 0; i < numEntries; i++) begin
                if (st.entries[i].valid && isOlder(st.entries[i].sqN, commitSqN)) begin
                    st.entries[i].ready <= 1'b1;
                end
            end

            // Address and mask arrive from the AGU
            if (agValid) begin
                st.entries[agIdx].addr <= agAddr[31:2];
                st.entries[agIdx].wmask <= agMask;
                st.entries[agIdx].addrAvail <= 1'b1;
            end

            // Data uses the mask written in an earlier cycle
            if (dataValid) begin
                st.entries[dataIdx].data <= alignData(dataIn, st.entries[dataIdx].wmask);
                st.entries[dataIdx].loaded <= 1'b1;
            end

            if (doAlloc) begin
                st.entries[tailIdx].valid <= 1'b1;
                st.entries[tailIdx].addrAvail <= 1'b0;
                st.entries[tailIdx].loaded <= 1'b0;
                st.entries[tailIdx].ready <= 1'b0;
                st.entries[tailIdx].sqN <= st.tail;
            end

            // Head retires when the drain stage takes it
            if (st.deq) begin
                st.entries[headIdx].valid <= 1'b0;
                st.entries[headIdx].ready <= 1'b0;
            end

            st.head <= nextHead;
            st.tail <= nextTail;
            full <= (nextCount == sqN_t'(numEntries));
            empty <= (nextCount == '0);
        end
    end

endmodule

/* design/sqDrain.sv */
`timescale 1ns/1ps

module sqDrain import sqPkg::*; #(
    parameter int numEntries = SQ_ENTRIES
) (
    input logic clk,
    input logic rst,

    // Memory port back-pressure
    input logic stall,

    // Outgoing store
    output logic stValid,
    output logic [31:0] stAddr,
    output logic [31:0] stData,
    output byteMask_t stMask,

    sqStateIf.drain st
);

    localparam int idxW = $clog2(numEntries);

    sqEntry_t headEntry;
    logic headDone;

    assign headEntry = st.entries[st.head[idxW-1:0]];

    // Head is committed and has both address and data
    assign headDone = headEntry.valid && headEntry.ready &&
                      headEntry.addrAvail && headEntry.loaded;

    assign st.deq = !stall && headDone;

    // Valid holds under stall, otherwise follows the retire strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            stValid <= 1'b0;
        end else if (!stall) begin
            stValid <= st.deq;
        end
    end

    // Payload only loads on a retire, so it also holds under stall
    always_ff @(posedge clk) begin
        if (st.deq) begin
            stAddr <= {headEntry.addr, 2'b00};
            stData <= headEntry.data;
            stMask <= headEntry.wmask;
        end
    end

endmodule

/* design/sqForward.sv */
`timescale 1ns/1ps

module sqForward import sqPkg::*; #(
    parameter int numEntries = SQ_ENTRIES
) (
    input logic clk,
    input logic rst,

    // Load query
    input logic ldValid,
    input logic [31:0] ldAddr,
    input logic [1:0] ldSize,
    input sqN_t ldSqN,

    // Forwarding result a cycle after the load
    output logic fwdValid,
    output logic [31:0] fwdData,
    output byteMask_t fwdMask,
    output logic fwdConflict,

    sqStateIf.lookup st
);

    localparam int idxW = $clog2(numEntries);

    byteMask_t readMask;
    sqN_t occupancy;

    logic [31:0] lookupData;
    byteMask_t lookupMask;
    logic lookupConflict;

    assign readMask = readMaskOf(ldSize, ldAddr[1:0]);
    assign occupancy = st.tail - st.head;

    // Walk oldest to youngest so younger stores overwrite per byte
    always_comb begin
        logic [idxW-1:0] idx;
        sqEntry_t e;
        logic match;

        // Unread bytes count as covered
        lookupMask = ~readMask;
        lookupData = '0;
        lookupConflict = 1'b0;

        for (int k = 0; k < numEntries; k++) begin
            idx = st.head[idxW-1:0] + idxW'(k);
            e = st.entries[idx];
            match = (sqN_t'(k) < occupancy) && e.valid && e.addrAvail &&
                    (e.addr == ldAddr[31:2]) &&
                    (isOlder(e.sqN, ldSqN) || e.ready);

            if (match) begin
                if (e.loaded) begin
                    for (int j = 0; j < 4; j++) begin
                        if (e.wmask[j]) begin
                            lookupData[j*8 +: 8] = e.data[j*8 +: 8];
                        end
                    end
                    lookupMask = lookupMask | e.wmask;
                end else if ((e.wmask & readMask) != '0) begin
                    // Overlapping store whose data is still missing
                    lookupConflict = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdValid <= 1'b0;
        end else begin
            fwdValid <= ldValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ldValid) begin
            fwdData <= lookupData;
            fwdMask <= lookupMask;
            fwdConflict <= lookupConflict;
        end
    end

endmodule

/* design/storeQueueTop.sv */
`timescale 1ns/1ps

module storeQueueTop import sqPkg::*; #(
    parameter int numEntries = SQ_ENTRIES
) (
    input logic clk,
    input logic rst,

    // Allocation
    input logic alloc,
    output sqN_t allocSqN,
    output logic full,

    // Address write
    input logic agValid,
    input sqN_t agSqN,
    input logic [31:0] agAddr,
    input byteMask_t agMask,

    // Data write
    input logic dataValid,
    input sqN_t dataSqN,
    input logic [31:0] dataIn,

    input sqN_t commitSqN,

    // Memory store port
    input logic stall,
    output logic stValid,
    output logic [31:0] stAddr,
    output logic [31:0] stData,
    output byteMask_t stMask,

    // Load forwarding
    input logic ldValid,
    input logic [31:0] ldAddr,
    input logic [1:0] ldSize,
    input sqN_t ldSqN,
    output logic fwdValid,
    output logic [31:0] fwdData,
    output byteMask_t fwdMask,
    output logic fwdConflict,

    output logic empty
);

    sqStateIf #(.numEntries(numEntries)) state_i ();

    sqEntryArray #(.numEntries(numEntries)) sqEntryArray_i (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .allocSqN(allocSqN),
        .full(full),
        .empty(empty),
        .agValid(agValid),
        .agSqN(agSqN),
        .agAddr(agAddr),
        .agMask(agMask),
        .dataValid(dataValid),
        .dataSqN(dataSqN),
        .dataIn(dataIn),
        .commitSqN(commitSqN),
        .st(state_i.array)
    );

    sqDrain #(.numEntries(numEntries)) sqDrain_i (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .stValid(stValid),
        .stAddr(stAddr),
        .stData(stData),
        .stMask(stMask),
        .st(state_i.drain)
    );

    sqForward #(.numEntries(numEntries)) sqForward_i (
        .clk(clk),
        .rst(rst),
        .ldValid(ldValid),
        .ldAddr(ldAddr),
        .ldSize(ldSize),
        .ldSqN(ldSqN),
        .fwdValid(fwdValid),
        .fwdData(fwdData),
        .fwdMask(fwdMask),
        .fwdConflict(fwdConflict),
        .st(state_i.lookup)
    );

endmodule

/* testbench/sqRefModel.svh */
`ifndef SQ_REF_MODEL_SVH
`define SQ_REF_MODEL_SVH

// Expected queue entries indexed by the low sqN bits
logic mValid [depth];
logic mAddrAvail [depth];
logic mLoaded [depth];
sqN_t mSqN [depth];
wordAddr_t mAddr [depth];
byteMask_t mMask [depth];
logic [31:0] mData [depth];

// Allocation counters that grow without wrapping
int refHead = 0;
int refTail = 0;
sqN_t refCommit = '0;

// Age from the signed distance between two wrapping sequence numbers
function automatic logic comesBefore(sqN_t a, sqN_t b);
    int span;
    int diff;
    span = 2 * depth;
    diff = int'(a) - int'(b);
    if (diff >= depth) diff = diff - span;
    if (diff < -depth) diff = diff + span;
    return diff < 0;
endfunction

// Store data as it should sit in the byte lanes
function automatic logic [31:0] placeInLanes(logic [31:0] raw, byteMask_t m);
    case (m)
        4'b0001: return {24'b0, raw[7:0]};
        4'b0010: return {16'b0, raw[7:0], 8'b0};
        4'b0100: return {8'b0, raw[7:0], 16'b0};
        4'b1000: return {raw[7:0], 24'b0};
        4'b0011: return {16'b0, raw[15:0]};
        4'b1100: return {raw[15:0], 16'b0};
        default: return raw;
    endcase
endfunction

function automatic logic [31:0] laneBits(byteMask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

function automatic byteMask_t bytesRead(logic [1:0] size, logic [1:0] offset);
    if (size == 2'd0) return byteMask_t'(4'b0001 << offset);
    if (size == 2'd1) return offset[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
endfunction

// Expected forward result from an oldest to youngest scan
function automatic void predictForward(input logic [31:0] addr, input logic [1:0] size,
                                       input sqN_t ldSqN, output logic [31:0] data,
                                       output byteMask_t mask, output logic conf);
    byteMask_t rd;
    int idx;
    rd = bytesRead(size, addr[1:0]);
    data = '0;
    mask = ~rd;
    conf = 1'b0;
    for (int k = refHead; k < refTail; k++) begin
        idx = k % depth;
        if (mValid[idx] && mAddrAvail[idx] && mAddr[idx] == addr[31:2] &&
            (comesBefore(mSqN[idx], ldSqN) || comesBefore(mSqN[idx], refCommit))) begin
            if (mLoaded[idx]) begin
                data = (data & ~laneBits(mMask[idx])) | (mData[idx] & laneBits(mMask[idx]));
                mask = mask | mMask[idx];
            end else if ((mMask[idx] & rd) != 4'b0000) begin
                conf = 1'b1;
            end
        end
    end
endfunction

`endif

/* testbench/storeQueueTb.sv */
`timescale 1ns/1ps

module storeQueueTb import sqPkg::*; ();

    localparam int depth = 8;
    localparam int cycleLimit = 400;

    logic clk;
    logic rst;
    logic alloc;
    sqN_t allocSqN;
    logic full;
    logic agValid;
    sqN_t agSqN;
    logic [31:0] agAddr;
    byteMask_t agMask;
    logic dataValid;
    sqN_t dataSqN;
    logic [31:0] dataIn;
    sqN_t commitSqN;
    logic stall;
    logic stValid;
    logic [31:0] stAddr;
    logic [31:0] stData;
    byteMask_t stMask;
    logic ldValid;
    logic [31:0] ldAddr;
    logic [1:0] ldSize;
    sqN_t ldSqN;
    logic fwdValid;
    logic [31:0] fwdData;
    byteMask_t fwdMask;
    logic fwdConflict;
    logic empty;

    storeQueueTop #(.numEntries(depth)) storeQueueTop_i (
        .clk(clk), .rst(rst), .alloc(alloc), .allocSqN(allocSqN), .full(full),
        .agValid(agValid), .agSqN(agSqN), .agAddr(agAddr), .agMask(agMask),
        .dataValid(dataValid), .dataSqN(dataSqN), .dataIn(dataIn), .commitSqN(commitSqN),
        .stall(stall), .stValid(stValid), .stAddr(stAddr), .stData(stData), .stMask(stMask),
        .ldValid(ldValid), .ldAddr(ldAddr), .ldSize(ldSize), .ldSqN(ldSqN),
        .fwdValid(fwdValid), .fwdData(fwdData), .fwdMask(fwdMask), .fwdConflict(fwdConflict),
        .empty(empty)
    );

    `include "sqRefModel.svh"

    int seed = 38875;
    int cycles = 0;
    int pushCount = 0;

    // Expected drained stores and load results in arrival order
    logic [31:0] qAddr [$];
    logic [31:0] qData [$];
    byteMask_t qMask [$];
    logic [31:0] fData [$];
    logic [31:0] fLanes [$];
    byteMask_t fMask [$];
    logic fConf [$];

    logic sampledStall = 1'b0;
    logic prevValid = 1'b0;
    logic [31:0] prevAddr;
    logic [31:0] prevData;
    byteMask_t prevMask;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Queue every store that may now drain up to the first blocked one
    task automatic pushDrainable();
        int idx;
        logic blocked;
        blocked = 1'b0;
        while (!blocked && pushCount < refTail) begin
            idx = pushCount % depth;
            if (comesBefore(mSqN[idx], refCommit) && mAddrAvail[idx] && mLoaded[idx]) begin
                qAddr.push_back({mAddr[idx], 2'b00});
                qData.push_back(mData[idx]);
                qMask.push_back(mMask[idx]);
                pushCount++;
            end else begin
                blocked = 1'b1;
            end
        end
    endtask

    task automatic allocStore();
        int idx;
        @(posedge clk);
        compareValue(32'(allocSqN), 32'(sqN_t'(refTail)), "allocSqN");
        alloc <= 1'b1;
        if (refTail - refHead < depth) begin
            idx = refTail % depth;
            mValid[idx] = 1'b1;
            mAddrAvail[idx] = 1'b0;
            mLoaded[idx] = 1'b0;
            mSqN[idx] = sqN_t'(refTail);
            refTail++;
        end
        @(posedge clk);
        alloc <= 1'b0;
    endtask

    task automatic writeAddr(input int n, input logic [31:0] addr, input byteMask_t m);
        @(posedge clk);
        agValid <= 1'b1;
        agSqN <= sqN_t'(n);
        agAddr <= addr;
        agMask <= m;
        mAddr[n % depth] = addr[31:2];
        mMask[n % depth] = m;
        mAddrAvail[n % depth] = 1'b1;
        @(posedge clk);
        agValid <= 1'b0;
    endtask

    task automatic writeData(input int n, input logic [31:0] raw);
        @(posedge clk);
        dataValid <= 1'b1;
        dataSqN <= sqN_t'(n);
        dataIn <= raw;
        mData[n % depth] = placeInLanes(raw, mMask[n % depth]);
        mLoaded[n % depth] = 1'b1;
        pushDrainable();
        @(posedge clk);
        dataValid <= 1'b0;
    endtask

    task automatic setCommit(input int n);
        @(posedge clk);
        commitSqN <= sqN_t'(n);
        refCommit = sqN_t'(n);
        pushDrainable();
    endtask

    task automatic issueLoad(input logic [31:0] addr, input logic [1:0] size, input int n);
        logic [31:0] d;
        byteMask_t m;
        logic c;
        @(posedge clk);
        ldValid <= 1'b1;
        ldAddr <= addr;
        ldSize <= size;
        ldSqN <= sqN_t'(n);
        predictForward(addr, size, sqN_t'(n), d, m, c);
        fData.push_back(d);
        fMask.push_back(m);
        fConf.push_back(c);
        fLanes.push_back(laneBits(m & bytesRead(size, addr[1:0])));
        @(posedge clk);
        ldValid <= 1'b0;
    endtask

    task automatic waitDrained();
        while (qAddr.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // Stall as the DUT saw it at the last edge
    always @(posedge clk) begin
        sampledStall <= stall;
    end

    always @(negedge clk) begin
        logic [31:0] lanes;
        if (!rst) begin
            if (sampledStall) begin
                compareValue(32'(stValid), 32'(prevValid), "stValid under stall");
                if (prevValid) begin
                    compareValue(stAddr, prevAddr, "stAddr under stall");
                    compareValue(stData, prevData, "stData under stall");
                    compareValue(32'(stMask), 32'(prevMask), "stMask under stall");
                end
            end else if (stValid) begin
                if (qAddr.size() == 0) stopOnError("A store drained before it was allowed to");
                lanes = laneBits(qMask[0]);
                compareValue(stAddr, qAddr.pop_front(), "stAddr");
                compareValue(stData & lanes, qData.pop_front() & lanes, "stData");
                compareValue(32'(stMask), 32'(qMask.pop_front()), "stMask");
                mValid[refHead % depth] = 1'b0;
                refHead++;
            end
            if (fwdValid) begin
                if (fData.size() == 0) stopOnError("A forward result came without a load");
                lanes = fLanes.pop_front();
                compareValue(32'(fwdMask), 32'(fMask.pop_front()), "fwdMask");
                compareValue(32'(fwdConflict), 32'(fConf.pop_front()), "fwdConflict");
                compareValue(fwdData & lanes, fData.pop_front() & lanes, "fwdData");
            end
            prevValid <= stValid;
            prevAddr <= stAddr;
            prevData <= stData;
            prevMask <= stMask;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) stopOnError("Timeout, the run did not finish in time");
    end

    initial begin
        byteMask_t maskTable [7];
        int order [depth];
        int r;
        int j;
        int t;
        logic [31:0] word;
        logic [31:0] addr;

        maskTable = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        rst <= 1'b1;
        alloc <= 1'b0;
        agValid <= 1'b0;
        agSqN <= '0;
        agAddr <= '0;
        agMask <= '0;
        dataValid <= 1'b0;
        dataSqN <= '0;
        dataIn <= '0;
        commitSqN <= '0;
        stall <= 1'b0;
        ldValid <= 1'b0;
        ldAddr <= '0;
        ldSize <= '0;
        ldSqN <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Fill the queue, then try one alloc too many
        for (int i = 0; i < depth; i++) allocStore();
        @(negedge clk);
        compareValue(32'(full), 32'd1, "full after fill");
        compareValue(32'(empty), 32'd0, "empty after fill");
        allocStore();
        @(negedge clk);
        compareValue(32'(allocSqN), 32'(depth), "allocSqN while full");

        // Stores 0 to 4 share one word for the forwarding checks
        word = $random(seed);
        word = word & 32'hffff_fffc;
        for (int i = 0; i < depth; i++) order[i] = i;
        for (int i = depth - 1; i > 0; i--) begin
            r = $random(seed);
            j = (r & 32'h7fff_ffff) % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < depth; i++) begin
            r = $random(seed);
            addr = $random(seed);
            case (order[i])
                0: writeAddr(0, word, 4'b0011);
                1: writeAddr(1, word, 4'b0011);
                2: writeAddr(2, word, 4'b0100);
                3: writeAddr(3, word, 4'b1000);
                4: writeAddr(4, word, 4'b1111);
                default: writeAddr(order[i], addr, maskTable[(r & 32'h7fff_ffff) % 7]);
            endcase
        end

        // Stores 3 and 5 keep their data back for now
        for (int i = 0; i < depth; i++) begin
            if (order[i] != 3 && order[i] != 5) writeData(order[i], $random(seed));
        end

        issueLoad(word, 2'd2, 4);
        issueLoad(word + 32'd1, 2'd0, 4);
        writeData(3, $random(seed));
        issueLoad(word, 2'd2, 4);
        issueLoad(word + 32'd2, 2'd1, 4);
        issueLoad(word + 32'd3, 2'd0, 3);

        // Store 5 lacks data, so only 0 to 4 may drain
        setCommit(7);
        waitDrained();

        writeData(5, $random(seed));
        setCommit(depth);
        @(posedge clk);
        while (!stValid) @(posedge clk);
        stall <= 1'b1;
        repeat (6) @(posedge clk);
        stall <= 1'b0;
        waitDrained();

        @(negedge clk);
        compareValue(32'(empty), 32'd1, "empty after drain");
        if (fData.size() != 0) begin
            stopOnError("Some load results never arrived");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+testbench
design/sqPkg.sv
design/sqStateIf.sv
design/sqEntryArray.sv
design/sqDrain.sv
design/sqForward.sv
design/storeQueueTop.sv
testbench/storeQueueTb.sv

/* run.sh */
#!/bin/sh
# Build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --top-module storeQueueTb -f filelist.f \
    --Mdir obj_dir -o storeQueueSim \
    && ./obj_dir/storeQueueSim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "Simulation passed" sim.log \
    && echo "Run finished without errors" \
    || { echo "Run failed, see sim.log"; exit 1; }
